/* Bender.yml */
package:
  name: rv_core

sources:
  - rv_core_pkg.sv
  - rv_decode.sv
  - rv_execute.sv
  - rv_writeback.sv
  - rv_core.sv
  - target: test
    files:
      - rv_core_assert.sv
      - tb_rv_core.sv

/* rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic               clk,
    input  logic               reset,
    input  logic               inst_valid,
    input  rv_core_pkg::inst_t inst,
    output rv_core_pkg::wb_t   retire
);
    import rv_core_pkg::*;

    dec_exe_t  dec;
    wb_t       res;
    reg_addr_t ra1;
    reg_addr_t ra2;
    word_t     rd1;
    word_t     rd2;

    rv_decode u_decode (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .ra1        (ra1),
        .ra2        (ra2),
        .rd1        (rd1),
        .rd2        (rd2),
        .wb         (retire),
        .dec        (dec)
    );

    rv_execute u_execute (
        .clk   (clk),
        .reset (reset),
        .dec   (dec),
        .res   (res)
    );

    rv_writeback u_writeback (
        .clk    (clk),
        .reset  (reset),
        .res    (res),
        .ra1    (ra1),
        .ra2    (ra2),
        .rd1    (rd1),
        .rd2    (rd2),
        .retire (retire)
    );

endmodule

`default_nettype wire

/* rv_core_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_assert (
    input logic             clk,
    input logic             reset,
    input logic             inst_valid,
    input rv_core_pkg::wb_t retire
);

    // nothing retires straight out of reset
    retire_idle_after_reset: assert property (@(posedge clk) $fell(reset) |=> !retire.valid)
        else $error("retire.valid high in the cycle after reset was released");

    // x0 is never a write target
    no_write_to_x0: assert property (@(posedge clk) disable iff (reset)
        retire.wr |-> retire.rd != '0)
        else $error("retire writes register x0");

    // a bubble leaves a hole two edges later
    bubble_never_retires: assert property (@(posedge clk) disable iff (reset)
        !inst_valid |-> ##2 !retire.valid)
        else $error("retire.valid high two edges after inst_valid was low");

endmodule

bind rv_core rv_core_assert u_core_assert (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .retire     (retire)
);

`default_nettype wire

/* rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

    // data path and register file geometry
    localparam int XLEN       = 32;
    localparam int REG_COUNT  = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [XLEN-1:0]       word_t;

    // major opcodes kept in this core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 encodings shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // selects sub and sra/srai
    localparam logic [6:0] F7_ALT = 7'b0100000;

    // instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef struct packed {
        logic [19:0] imm20;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } inst_u_t;

    // one instruction word, three views
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_u_t u;
    } inst_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    // decode to execute pipeline register
    typedef struct packed {
        logic      valid;
        logic      wr;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      use_rs2;
        alu_op_t   alu_op;
        word_t     op_a;
        word_t     op_b;
    } dec_exe_t;

    // one finished result, also the retire record
    typedef struct packed {
        logic      valid;
        logic      wr;
        reg_addr_t rd;
        word_t     value;
    } wb_t;

endpackage

`default_nettype wire

/* rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inst_valid,
    input  rv_core_pkg::inst_t    inst,
    output rv_core_pkg::reg_addr_t ra1,
    output rv_core_pkg::reg_addr_t ra2,
    input  rv_core_pkg::word_t    rd1,
    input  rv_core_pkg::word_t    rd2,
    input  rv_core_pkg::wb_t      wb,
    output rv_core_pkg::dec_exe_t dec
);
    import rv_core_pkg::*;

    logic     supported;
    logic     use_rs2;
    logic     is_lui;
    alu_op_t  alu_op;
    word_t    imm;
    word_t    rs1_val;
    word_t    rs2_val;
    dec_exe_t dec_d;

    // funct3 mapping common to register and immediate forms
    function automatic alu_op_t base_op(input logic [2:0] f3);
        case (f3)
            F3_ADD_SUB: return ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SR:      return ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    assign ra1 = inst.r.rs1;
    assign ra2 = inst.r.rs2;

    // writeback bypass, the register file writes on this same edge
    assign rs1_val = (wb.valid && wb.wr && wb.rd == ra1) ? wb.value : rd1;
    assign rs2_val = (wb.valid && wb.wr && wb.rd == ra2) ? wb.value : rd2;

    assign is_lui = (inst.r.opcode == OPC_LUI);

    always_comb begin
        supported = 1'b1;
        use_rs2   = 1'b0;
        alu_op    = base_op(inst.r.funct3);
        imm       = {{(XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};
        case (inst.r.opcode)
            OPC_OP: begin
                use_rs2 = 1'b1;
                if (inst.r.funct7 == F7_ALT) begin
                    if (inst.r.funct3 == F3_ADD_SUB) begin
                        alu_op = ALU_SUB;
                    end else if (inst.r.funct3 == F3_SR) begin
                        alu_op = ALU_SRA;
                    end else begin
                        supported = 1'b0;
                    end
                end else if (inst.r.funct7 != '0) begin
                    supported = 1'b0;
                end
            end
            OPC_OP_IMM: begin
                // shifts keep funct7 in the top of imm12
                if (inst.i.funct3 == F3_SLL || inst.i.funct3 == F3_SR) begin
                    imm = {{(XLEN-5){1'b0}}, inst.i.imm12[4:0]};
                    if (inst.i.funct3 == F3_SR && inst.r.funct7 == F7_ALT) begin
                        alu_op = ALU_SRA;
                    end else if (inst.r.funct7 != '0) begin
                        supported = 1'b0;
                    end
                end
            end
            OPC_LUI: begin
                alu_op = ALU_PASS_B;
                imm    = {inst.u.imm20, 12'b0};
            end
            default: supported = 1'b0;
        endcase
    end

    always_comb begin
        dec_d.valid   = inst_valid && supported;
        dec_d.wr      = inst_valid && supported && (inst.r.rd != '0);
        dec_d.rd      = inst.r.rd;
        // lui has no source register, keep execute from forwarding into it
        dec_d.rs1     = is_lui ? '0 : inst.r.rs1;
        dec_d.rs2     = inst.r.rs2;
        dec_d.use_rs2 = use_rs2;
        dec_d.alu_op  = alu_op;
        dec_d.op_a    = is_lui ? '0 : rs1_val;
        dec_d.op_b    = use_rs2 ? rs2_val : imm;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec.valid <= 1'b0;
            dec.wr    <= 1'b0;
        end else begin
            dec <= dec_d;
        end
    end

endmodule

`default_nettype wire

/* rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_core_pkg::dec_exe_t dec,
    output rv_core_pkg::wb_t      res
);
    import rv_core_pkg::*;

    logic  fwd_a;
    logic  fwd_b;
    word_t a;
    word_t b;
    word_t alu_out;

    // result register feeds back to the next instruction
    assign fwd_a = res.valid && res.wr && (res.rd == dec.rs1);
    assign fwd_b = res.valid && res.wr && dec.use_rs2 && (res.rd == dec.rs2);

    assign a = fwd_a ? res.value : dec.op_a;
    assign b = fwd_b ? res.value : dec.op_b;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_out = a + b;
            ALU_SUB:  alu_out = a - b;
            ALU_SLL:  alu_out = a << b[4:0];
            ALU_SLT:  alu_out = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: alu_out = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:  alu_out = a ^ b;
            ALU_SRL:  alu_out = a >> b[4:0];
            // arithmetic shift keeps the sign
            ALU_SRA:  alu_out = $signed(a) >>> b[4:0];
            ALU_OR:   alu_out = a | b;
            ALU_AND:  alu_out = a & b;
            default:  alu_out = b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res.valid <= 1'b0;
            res.wr    <= 1'b0;
        end else begin
            res.valid <= dec.valid;
            res.wr    <= dec.wr;
        end
        res.rd    <= dec.rd;
        res.value <= alu_out;
    end

endmodule

`default_nettype wire

/* rv_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_writeback (
    input  logic                   clk,
    input  logic                   reset,
    input  rv_core_pkg::wb_t       res,
    input  rv_core_pkg::reg_addr_t ra1,
    input  rv_core_pkg::reg_addr_t ra2,
    output rv_core_pkg::word_t     rd1,
    output rv_core_pkg::word_t     rd2,
    output rv_core_pkg::wb_t       retire
);
    import rv_core_pkg::*;

    word_t regs [REG_COUNT];

    // wr is never set for x0, so entry 0 stays zero after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (res.valid && res.wr) begin
            regs[res.rd] <= res.value;
        end
    end

    // read ports, no clock
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

    // the result register is the retire record
    assign retire = res;

endmodule

`default_nettype wire

/* sources.f */
rv_core_pkg.sv
rv_decode.sv
rv_execute.sv
rv_writeback.sv
rv_core.sv
rv_core_assert.sv
tb_rv_core.sv

/* tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
    import rv_core_pkg::*;

    localparam int SEED         = 80709;
    localparam int NUM_INST     = 2000;
    localparam int DRAIN_CYCLES = 4;
    localparam int CLK_PERIOD   = 8;

    // funct3 per alu kind: add sub sll slt sltu xor srl sra or and
    localparam logic [2:0] KIND_F3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                           3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    // alu kind of addi slti sltiu xori ori andi slli srli srai
    localparam int IMM_KIND [9] = '{0, 3, 4, 5, 8, 9, 2, 6, 7};

    typedef struct packed {
        reg_addr_t rd;
        word_t     value;
        int        sample_edge;
    } retire_exp_t;

    logic        clk;
    logic        reset;
    logic        inst_valid;
    inst_t       inst;
    wb_t         retire;
    integer      seed;
    int          edge_cnt = 0;
    word_t       model_regs [REG_COUNT];
    retire_exp_t exp_q [$];
    retire_exp_t head;

    rv_core dut0 (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .retire     (retire)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_failed(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            stop_failed($sformatf("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, want));
        end
    endtask

    // results taken from the RV32I definitions
    function automatic word_t alu_model(input int kind, input word_t a, input word_t b);
        word_t r;
        int    sh;
        sh = b[4:0];
        case (kind)
            0: r = a + b;
            1: r = a + ~b + 32'd1;
            2: r = a << sh;
            3: r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            4: r = {31'b0, a < b};
            5: r = a ^ b;
            6: r = a >> sh;
            // vacated top bits take the sign
            7: r = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            8: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // mostly x0..x3 so dependences land close together
    function automatic reg_addr_t pick_reg();
        logic [31:0] rnd;
        rnd = $random(seed);
        if (rnd[3:0] < 4'd13) begin
            return {3'b000, rnd[5:4]};
        end else begin
            return rnd[10:6];
        end
    endfunction

    task automatic drive_random();
        int unsigned sel;
        int          kind;
        logic [31:0] rnd;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [6:0]  f7;
        logic [11:0] imm12;
        word_t       b;
        word_t       value;
        sel   = {$random(seed)} % 100;
        rnd   = $random(seed);
        rd    = pick_reg();
        rs1   = pick_reg();
        rs2   = pick_reg();
        kind  = rnd[15:0] % 20;
        imm12 = rnd[31:20];
        inst_valid = 1'b1;
        if (sel < 15) begin
            // random word that must be ignored
            inst_valid = 1'b0;
            inst       = $random(seed);
        end else if (sel < 20) begin
            // M extension, bad funct7 on xor or slli, and a load
            case (rnd[17:16])
                2'd0:    inst = {7'b0000001, rs2, rs1, rnd[2:0], rd, OPC_OP};
                2'd1:    inst = {F7_ALT, rs2, rs1, 3'b100, rd, OPC_OP};
                2'd2:    inst = {F7_ALT, rs2, rs1, 3'b001, rd, OPC_OP_IMM};
                default: inst = {imm12, rs1, 3'b010, rd, 7'b0000011};
            endcase
        end else if (kind < 10) begin
            f7    = (kind == 1 || kind == 7) ? F7_ALT : 7'b0;
            inst  = {f7, rs2, rs1, KIND_F3[kind], rd, OPC_OP};
            value = alu_model(kind, model_regs[rs1], model_regs[rs2]);
        end else if (kind < 19) begin
            kind = IMM_KIND[kind - 10];
            if (kind == 2 || kind == 6 || kind == 7) begin
                // shift amount in the low five bits, funct7 above it
                imm12[11:5] = (kind == 7) ? F7_ALT : 7'b0;
                b = {27'b0, imm12[4:0]};
            end else begin
                b = {{20{imm12[11]}}, imm12};
            end
            inst  = {imm12, rs1, KIND_F3[kind], rd, OPC_OP_IMM};
            value = alu_model(kind, model_regs[rs1], b);
        end else begin
            inst  = {rnd[31:12], rd, OPC_LUI};
            value = {rnd[31:12], 12'h000};
        end
        if (sel >= 20) begin
            if (rd != '0) begin
                model_regs[rd] = value;
            end
            exp_q.push_back(retire_exp_t'{rd, value, edge_cnt + 1});
        end
    endtask

    // retire holds its value up to this edge
    always @(posedge clk) begin
        edge_cnt = edge_cnt + 1;
        if (!reset) begin
            if ($isunknown(retire.valid)) begin
                stop_failed("retire.valid is unknown after reset");
            end else if (retire.valid && exp_q.size() == 0) begin
                stop_failed("an instruction retired that was never issued");
            end else if (retire.valid) begin
                head = exp_q.pop_front();
                check_value("retire.rd", retire.rd, head.rd);
                check_value("retire.wr", retire.wr, head.rd != '0);
                check_value("retire.value", retire.value, head.value);
                check_value("retire edge", edge_cnt, head.sample_edge + 2);
            end
        end
    end

    initial begin
        seed       = SEED;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        for (int i = 0; i < REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int n = 0; n < NUM_INST; n++) begin
            drive_random();
            @(negedge clk);
        end
        inst_valid = 1'b0;
        repeat (DRAIN_CYCLES) @(negedge clk);
        if (exp_q.size() != 0) begin
            stop_failed($sformatf("%0d issued instructions never retired", exp_q.size()));
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

    initial begin
        #((NUM_INST + 20) * CLK_PERIOD);
        stop_failed("watchdog expired before the run finished");
    end

endmodule

`default_nettype wire
